// ==== ctrl_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_merge (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            jump_load,
  input  logic [sys_cont_pkg::ADDR_W-1:0] jump_load_address,
  input  logic                            jump_load_cs,
  input  logic [sys_cont_pkg::SEL_W-1:0]  jump_cs,
  input  logic                            int_fetch_load,
  input  logic [sys_cont_pkg::ADDR_W-1:0] int_fetch_addr,
  input  logic                            int_flush,
  input  logic                            iretd_halt,
  input  logic                            ret_load_eflags,
  input  logic                            ret_load_cs,
  input  logic [sys_cont_pkg::SEL_W-1:0]  ret_cs,
  input  logic                            ret_load_eip,
  input  logic [sys_cont_pkg::ADDR_W-1:0] ret_eip,
  input  logic                            ret_fetch_load,
  input  logic [sys_cont_pkg::ADDR_W-1:0] ret_fetch_addr,
  output logic                            flush_fetch,
  output logic                            flush_decode_0,
  output logic                            flush_decode_1,
  output logic                            flush_register,
  output logic                            flush_address,
  output logic                            flush_execute,
  output logic                            flush_writeback,
  output logic                            fetch_load,
  output logic [sys_cont_pkg::ADDR_W-1:0] fetch_load_address,
  output logic                            reg_load_cs,
  output logic [sys_cont_pkg::SEL_W-1:0]  reg_cs,
  output logic                            reg_load_eflags,
  output logic [sys_cont_pkg::ADDR_W-1:0] reg_eflags,
  output logic                            reg_load_eip,
  output logic [sys_cont_pkg::ADDR_W-1:0] reg_eip
);

  logic                            jmp_load_q;
  logic                            jmp_load_cs_q;
  logic [sys_cont_pkg::ADDR_W-1:0] jmp_addr_q;
  logic [sys_cont_pkg::SEL_W-1:0]  jmp_cs_q;
  logic                            pipe_flush;

  //////////////////////////////
  // jump capture

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      jmp_load_q    <= 1'b0;
      jmp_load_cs_q <= 1'b0;
    end else begin
      jmp_load_q    <= jump_load;
      jmp_load_cs_q <= jump_load_cs;
    end
  end

  always_ff @(posedge clk) begin
    jmp_addr_q <= jump_load_address;
    jmp_cs_q   <= jump_cs;
  end

  //////////////////////////////
  // merge

  // interrupt flushes all seven stages, a jump spares writeback
  assign pipe_flush = int_flush || jmp_load_q;

  assign flush_fetch     = pipe_flush || iretd_halt;
  assign flush_decode_0  = pipe_flush;
  assign flush_decode_1  = pipe_flush;
  assign flush_register  = pipe_flush;
  assign flush_address   = pipe_flush;
  assign flush_execute   = pipe_flush;
  assign flush_writeback = int_flush;

  assign fetch_load = int_fetch_load || ret_fetch_load || jmp_load_q;

  // interrupt first, then return, then jump
  assign fetch_load_address = int_fetch_load ? int_fetch_addr :
                              ret_fetch_load ? ret_fetch_addr : jmp_addr_q;

  assign reg_load_cs = ret_load_cs || (jmp_load_q && jmp_load_cs_q);
  assign reg_cs      = ret_load_cs ? ret_cs : jmp_cs_q;

  // eflags and eip both come off the same popped word
  assign reg_load_eflags = ret_load_eflags;
  assign reg_eflags      = ret_eip;
  assign reg_load_eip    = ret_load_eip;
  assign reg_eip         = ret_eip;

  a_fetch_src : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({int_fetch_load, ret_fetch_load, jmp_load_q})
  ) else $warning("fetch redirect sources coincide, lower priority address dropped");

endmodule

`default_nettype wire

// ==== int_pending.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_pending (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [sys_cont_pkg::NUM_VEC-1:0]   int_vec,
  input  logic                               clear_en,
  input  logic [sys_cont_pkg::VEC_IDX_W-1:0] clear_idx,
  output logic [sys_cont_pkg::NUM_VEC-1:0]   pending,
  output logic                               any_pending,
  output logic [sys_cont_pkg::VEC_IDX_W-1:0] sel_idx
);

  logic [sys_cont_pkg::NUM_VEC-1:0] clear_mask;
  logic [sys_cont_pkg::NUM_VEC-1:0] pending_d;

  always_comb begin
    clear_mask = '0;
    if (clear_en) begin
      clear_mask[clear_idx] = 1'b1;
    end
  end

  // new requests are ORed in after the clear, so a set wins
  assign pending_d = (pending & ~clear_mask) | int_vec;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
    end else begin
      pending <= pending_d;
    end
  end

  assign any_pending = |pending;

  // scan from the top so the lowest set index is left last
  always_comb begin
    sel_idx = '0;
    for (int i = sys_cont_pkg::NUM_VEC - 1; i >= 0; i--) begin
      if (pending[i]) begin
        sel_idx = (sys_cont_pkg::VEC_IDX_W)'(i);
      end
    end
  end

  // the sequencer only ever retires a line it is serving
  a_clear_pending : assert property (
    @(posedge clk) disable iff (!arst_n)
    clear_en |-> pending[clear_idx]
  ) else $error("clear of interrupt line %0d that is not pending", clear_idx);

endmodule

`default_nettype wire

// ==== int_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_seq (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                any_pending,
  input  logic [sys_cont_pkg::VEC_IDX_W-1:0]  sel_idx,
  input  logic                                hold_int,
  output logic                                mem_valid,
  input  logic                                mem_ready,
  output logic [sys_cont_pkg::ADDR_W-1:0]     mem_address,
  input  logic                                mem_dp_valid,
  output logic                                mem_dp_ready,
  input  logic [sys_cont_pkg::ADDR_W-1:0]     mem_dp_read_data,
  output logic                                decode_start_int,
  input  logic                                decode_end_int,
  output logic                                int_fetch_load,
  output logic [sys_cont_pkg::ADDR_W-1:0]     int_fetch_addr,
  output logic                                int_flush,
  output logic                                clear_en,
  output logic [sys_cont_pkg::VEC_IDX_W-1:0]  clear_idx
);

  logic [1:0]                         state_q;
  logic [1:0]                         state_d;
  logic [sys_cont_pkg::VEC_IDX_W-1:0] idx_q;

  //////////////////////////////
  // state and serviced index

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= sys_cont_pkg::INT_IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      // index is frozen for the whole service while later requests just pend
      if (state_q == sys_cont_pkg::INT_IDLE) begin
        idx_q <= sel_idx;
      end
    end
  end

  //////////////////////////////
  // next state and strobes

  always_comb begin
    state_d          = state_q;
    mem_valid        = 1'b0;
    mem_dp_ready     = 1'b0;
    int_fetch_load   = 1'b0;
    int_flush        = 1'b0;
    decode_start_int = 1'b0;
    clear_en         = 1'b0;
    case (state_q)
      sys_cont_pkg::INT_IDLE: begin
        if (any_pending && !hold_int) begin
          state_d = sys_cont_pkg::INT_REQ;
        end
      end
      sys_cont_pkg::INT_REQ: begin
        mem_valid = 1'b1;
        if (mem_ready) begin
          state_d = sys_cont_pkg::INT_DATA;
        end
      end
      sys_cont_pkg::INT_DATA: begin
        mem_dp_ready = 1'b1;
        // the handler address redirects fetch, flushes everything and hands off to decode
        if (mem_dp_valid) begin
          int_fetch_load   = 1'b1;
          int_flush        = 1'b1;
          decode_start_int = 1'b1;
          state_d          = sys_cont_pkg::INT_WAIT;
        end
      end
      default: begin
        if (decode_end_int) begin
          clear_en = 1'b1;
          state_d  = sys_cont_pkg::INT_IDLE;
        end
      end
    endcase
  end

  assign mem_address    = sys_cont_pkg::idt_addr(idx_q);
  assign int_fetch_addr = mem_dp_read_data;
  assign clear_idx      = idx_q;

  a_req_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_address)
  ) else $error("vector table request dropped or changed before mem_ready");

endmodule

`default_nettype wire

// ==== ret_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ret_unit (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            iretd,
  input  logic                            ret_far,
  input  logic                            ret_near,
  input  logic                            iretd_pop_valid,
  input  logic [sys_cont_pkg::ADDR_W-1:0] iretd_pop_data,
  input  logic [sys_cont_pkg::SEL_W-1:0]  cs_register,
  output logic                            iretd_halt,
  output logic                            ret_load_eflags,
  output logic                            ret_load_cs,
  output logic [sys_cont_pkg::SEL_W-1:0]  ret_cs,
  output logic                            ret_load_eip,
  output logic [sys_cont_pkg::ADDR_W-1:0] ret_eip,
  output logic                            ret_fetch_load,
  output logic [sys_cont_pkg::ADDR_W-1:0] ret_fetch_addr
);

  logic [2:0]                       state_q;
  logic [2:0]                       state_d;
  logic                             near_q;
  logic [sys_cont_pkg::SEL_W-1:0]   cs_tmp_q;
  logic [sys_cont_pkg::SEL_W-1:0]   used_cs;

  //////////////////////////////
  // sequencer

  always_comb begin
    state_d = state_q;
    case (state_q)
      sys_cont_pkg::RET_IDLE: begin
        // entry point depends on how many words the return pops
        if (iretd) begin
          state_d = sys_cont_pkg::RET_EFLAGS;
        end else if (ret_far) begin
          state_d = sys_cont_pkg::RET_CS;
        end else if (ret_near) begin
          state_d = sys_cont_pkg::RET_EIP;
        end
      end
      sys_cont_pkg::RET_EFLAGS: begin
        if (iretd_pop_valid) begin
          state_d = sys_cont_pkg::RET_CS;
        end
      end
      sys_cont_pkg::RET_CS: begin
        if (iretd_pop_valid) begin
          state_d = sys_cont_pkg::RET_EIP;
        end
      end
      sys_cont_pkg::RET_EIP: begin
        if (iretd_pop_valid) begin
          state_d = sys_cont_pkg::RET_IDLE;
        end
      end
      default: state_d = sys_cont_pkg::RET_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= sys_cont_pkg::RET_IDLE;
      near_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == sys_cont_pkg::RET_IDLE) begin
        near_q <= ret_near && !iretd && !ret_far;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ret_load_cs) begin
      cs_tmp_q <= iretd_pop_data[sys_cont_pkg::SEL_W-1:0];
    end
  end

  //////////////////////////////
  // one load per consumed pop

  assign ret_load_eflags = iretd_pop_valid && (state_q == sys_cont_pkg::RET_EFLAGS);
  assign ret_load_cs     = iretd_pop_valid && (state_q == sys_cont_pkg::RET_CS);
  assign ret_load_eip    = iretd_pop_valid && (state_q == sys_cont_pkg::RET_EIP);
  assign ret_fetch_load  = ret_load_eip;

  assign ret_cs  = iretd_pop_data[sys_cont_pkg::SEL_W-1:0];
  assign ret_eip = iretd_pop_data;

  // near return stays in the current segment
  assign used_cs        = near_q ? cs_register : cs_tmp_q;
  assign ret_fetch_addr = iretd_pop_data
                        + {{(sys_cont_pkg::ADDR_W - sys_cont_pkg::SEL_W){1'b0}}, used_cs};

  assign iretd_halt = (state_q != sys_cont_pkg::RET_IDLE);

endmodule

`default_nettype wire

// ==== sys_cont_pkg.sv ====
`default_nettype none

package sys_cont_pkg;

  //////////////////////////////
  // widths

  localparam int ADDR_W    = 32;
  localparam int SEL_W     = 16;
  localparam int NUM_VEC   = 4;
  localparam int VEC_IDX_W = 2;

  //////////////////////////////
  // interrupt vector table

  localparam logic [ADDR_W-1:0] IDT_ADDR0 = 32'h0000_4000;
  localparam logic [ADDR_W-1:0] IDT_ADDR1 = 32'h0000_8000;
  localparam logic [ADDR_W-1:0] IDT_ADDR2 = 32'h0000_c000;
  localparam logic [ADDR_W-1:0] IDT_ADDR3 = 32'h0000_f000;

  // table entry for one vector index
  function automatic logic [ADDR_W-1:0] idt_addr(input logic [VEC_IDX_W-1:0] idx);
    logic [ADDR_W-1:0] addr;
    case (idx)
      2'd0:    addr = IDT_ADDR0;
      2'd1:    addr = IDT_ADDR1;
      2'd2:    addr = IDT_ADDR2;
      default: addr = IDT_ADDR3;
    endcase
    return addr;
  endfunction

  //////////////////////////////
  // return sequencer states

  // one state per popped word, in stack order
  localparam logic [2:0] RET_IDLE   = 3'd0;
  localparam logic [2:0] RET_EFLAGS = 3'd1;
  localparam logic [2:0] RET_CS     = 3'd2;
  localparam logic [2:0] RET_EIP    = 3'd3;

  //////////////////////////////
  // interrupt sequencer states

  localparam logic [1:0] INT_IDLE = 2'd0;
  localparam logic [1:0] INT_REQ  = 2'd1;
  localparam logic [1:0] INT_DATA = 2'd2;
  localparam logic [1:0] INT_WAIT = 2'd3;

endpackage

`default_nettype wire

// ==== sys_cont_top.f ====
sys_cont_pkg.sv
int_pending.sv
int_seq.sv
ret_unit.sv
ctrl_merge.sv
sys_cont_top.sv
tb_sys_cont.sv

// ==== sys_cont_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_cont_top (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [sys_cont_pkg::NUM_VEC-1:0]    int_vec,
  input  logic [sys_cont_pkg::SEL_W-1:0]      cs_register,
  output logic                                mem_valid,
  input  logic                                mem_ready,
  output logic [sys_cont_pkg::ADDR_W-1:0]     mem_address,
  input  logic                                mem_dp_valid,
  output logic                                mem_dp_ready,
  input  logic [sys_cont_pkg::ADDR_W-1:0]     mem_dp_read_data,
  output logic                                flush_fetch,
  output logic                                flush_decode_0,
  output logic                                flush_decode_1,
  output logic                                flush_register,
  output logic                                flush_address,
  output logic                                flush_execute,
  output logic                                flush_writeback,
  output logic                                fetch_load,
  output logic [sys_cont_pkg::ADDR_W-1:0]     fetch_load_address,
  output logic                                decode_start_int,
  input  logic                                decode_end_int,
  output logic                                reg_load_cs,
  output logic [sys_cont_pkg::SEL_W-1:0]      reg_cs,
  input  logic                                ret_near,
  input  logic                                ret_far,
  input  logic                                iretd,
  output logic                                iretd_halt,
  input  logic                                iretd_pop_valid,
  input  logic [sys_cont_pkg::ADDR_W-1:0]     iretd_pop_data,
  output logic                                reg_load_eflags,
  output logic [sys_cont_pkg::ADDR_W-1:0]     reg_eflags,
  output logic                                reg_load_eip,
  output logic [sys_cont_pkg::ADDR_W-1:0]     reg_eip,
  output logic                                pending_int,
  input  logic                                hold_int,
  input  logic                                jump_load,
  input  logic [sys_cont_pkg::ADDR_W-1:0]     jump_load_address,
  input  logic                                jump_load_cs,
  input  logic [sys_cont_pkg::SEL_W-1:0]      jump_cs
);

  // interrupt side
  logic [sys_cont_pkg::VEC_IDX_W-1:0] sel_idx;
  logic                               clear_en;
  logic [sys_cont_pkg::VEC_IDX_W-1:0] clear_idx;
  logic                               int_fetch_load;
  logic [sys_cont_pkg::ADDR_W-1:0]    int_fetch_addr;
  logic                               int_flush;

  // return side
  logic                               ret_load_eflags;
  logic                               ret_load_cs;
  logic [sys_cont_pkg::SEL_W-1:0]     ret_cs;
  logic                               ret_load_eip;
  logic [sys_cont_pkg::ADDR_W-1:0]    ret_eip;
  logic                               ret_fetch_load;
  logic [sys_cont_pkg::ADDR_W-1:0]    ret_fetch_addr;

  int_pending u_int_pending (
    .pending     (),
    .any_pending (pending_int),
    .*
  );

  int_seq u_int_seq (
    .any_pending (pending_int),
    .*
  );

  ret_unit u_ret_unit (
    .*
  );

  ctrl_merge u_ctrl_merge (
    .*
  );

endmodule

`default_nettype wire

// ==== tb_sys_cont.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sys_cont;

  localparam int N_JUMP    = 16;
  localparam int N_ROUND   = 4;
  localparam int N_HOLD    = 3;
  localparam int N_RET     = 8;
  // rough upper bounds in cycles for one interrupt service and one return
  localparam int SERVE_MAX = 20;
  localparam int RET_MAX   = 18;
  localparam int RUN_MAX   = 20 + N_JUMP * 3 + N_ROUND * 4 * SERVE_MAX
                           + N_HOLD * (8 + 4 * SERVE_MAX) + 2 * N_RET * RET_MAX + 10;
  localparam int LIMIT     = 4 * RUN_MAX;

  logic        clk;
  logic        arst_n;
  logic [3:0]  int_vec;
  logic [15:0] cs_register;
  logic        mem_valid;
  logic        mem_ready;
  logic [31:0] mem_address;
  logic        mem_dp_valid;
  logic        mem_dp_ready;
  logic [31:0] mem_dp_read_data;
  logic        flush_fetch;
  logic        flush_decode_0;
  logic        flush_decode_1;
  logic        flush_register;
  logic        flush_address;
  logic        flush_execute;
  logic        flush_writeback;
  logic        fetch_load;
  logic [31:0] fetch_load_address;
  logic        decode_start_int;
  logic        decode_end_int;
  logic        reg_load_cs;
  logic [15:0] reg_cs;
  logic        ret_near;
  logic        ret_far;
  logic        iretd;
  logic        iretd_halt;
  logic        iretd_pop_valid;
  logic [31:0] iretd_pop_data;
  logic        reg_load_eflags;
  logic [31:0] reg_eflags;
  logic        reg_load_eip;
  logic [31:0] reg_eip;
  logic        pending_int;
  logic        hold_int;
  logic        jump_load;
  logic [31:0] jump_load_address;
  logic        jump_load_cs;
  logic [15:0] jump_cs;

  logic [6:0]  flushes;
  logic [3:0]  model_pending;
  logic [3:0]  mask;
  logic [3:0]  inject;
  integer      seed;
  int          errors;
  int          checks;
  int          tests_failed;
  int          err0;
  int          cycles;

  assign flushes = {flush_fetch, flush_decode_0, flush_decode_1, flush_register,
                    flush_address, flush_execute, flush_writeback};

  sys_cont_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // helpers

  function automatic logic [1:0] lowest_set(input logic [3:0] m);
    casez (m)
      4'b???1: lowest_set = 2'd0;
      4'b??10: lowest_set = 2'd1;
      4'b?100: lowest_set = 2'd2;
      default: lowest_set = 2'd3;
    endcase
  endfunction

  // vector table entries
  function automatic logic [31:0] vector_addr(input logic [1:0] idx);
    case (idx)
      2'd0:    vector_addr = 32'h4000;
      2'd1:    vector_addr = 32'h8000;
      2'd2:    vector_addr = 32'hc000;
      default: vector_addr = 32'hf000;
    endcase
  endfunction

  task automatic next_cycle;
    @(negedge clk);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
    end
  endtask

  task automatic check_quiet;
    compare("flush_*", flushes, 0);
    compare("mem_valid", mem_valid, 0);
    compare("mem_dp_ready", mem_dp_ready, 0);
    compare("decode_start_int", decode_start_int, 0);
    compare("iretd_halt", iretd_halt, 0);
    compare("pending_int", pending_int, 0);
    compare("fetch_load", fetch_load, 0);
    compare("reg_load_cs", reg_load_cs, 0);
    compare("reg_load_eflags", reg_load_eflags, 0);
    compare("reg_load_eip", reg_load_eip, 0);
  endtask

  //////////////////////////////
  // stimulus per behavior

  task automatic run_jump;
    logic [31:0] addr;
    logic [15:0] cs;
    logic        with_cs;
    addr = $random(seed);
    cs = $random(seed);
    with_cs = $random(seed);
    jump_load = 1'b1;
    jump_load_address = addr;
    jump_load_cs = with_cs;
    jump_cs = cs;
    next_cycle();
    // address and cs are don't care while jump_load is low
    jump_load = 1'b0;
    jump_load_cs = $random(seed);
    jump_load_address = $random(seed);
    jump_cs = $random(seed);
    #1;
    compare("fetch_load", fetch_load, 1);
    compare("fetch_load_address", fetch_load_address, addr);
    compare("flush_*", flushes, 7'b111_1110);
    compare("reg_load_cs", reg_load_cs, with_cs);
    if (with_cs) begin
      compare("reg_cs", reg_cs, cs);
    end
    next_cycle();
    #1;
    compare("fetch_load", fetch_load, 0);
    compare("flush_*", flushes, 0);
    next_cycle();
  endtask

  // one vector fetch with random memory latency where inject lands during the wait
  task automatic serve_one(input logic [3:0] inj);
    logic [1:0]  idx;
    logic [31:0] word;
    int          d;
    idx = lowest_set(model_pending);
    while (mem_valid !== 1'b1) begin
      next_cycle();
    end
    compare("mem_address", mem_address, vector_addr(idx));
    d = {$random(seed)} % 4;
    repeat (d) begin
      #1;
      compare("mem_valid", mem_valid, 1);
      compare("mem_address", mem_address, vector_addr(idx));
      next_cycle();
    end
    mem_ready = 1'b1;
    next_cycle();
    mem_ready = 1'b0;
    d = {$random(seed)} % 4;
    repeat (d) begin
      #1;
      compare("mem_valid", mem_valid, 0);
      compare("mem_dp_ready", mem_dp_ready, 1);
      compare("fetch_load", fetch_load, 0);
      next_cycle();
    end
    word = $random(seed);
    mem_dp_valid = 1'b1;
    mem_dp_read_data = word;
    #1;
    compare("mem_dp_ready", mem_dp_ready, 1);
    compare("fetch_load", fetch_load, 1);
    compare("fetch_load_address", fetch_load_address, word);
    compare("flush_*", flushes, 7'h7f);
    compare("decode_start_int", decode_start_int, 1);
    next_cycle();
    mem_dp_valid = 1'b0;
    mem_dp_read_data = $random(seed);
    int_vec = inj;
    model_pending = model_pending | inj;
    #1;
    compare("decode_start_int", decode_start_int, 0);
    compare("fetch_load", fetch_load, 0);
    next_cycle();
    int_vec = 4'd0;
    d = {$random(seed)} % 4;
    repeat (d) begin
      next_cycle();
    end
    decode_end_int = 1'b1;
    next_cycle();
    decode_end_int = 1'b0;
    model_pending[idx] = 1'b0;
    #1;
    compare("pending_int", pending_int, |model_pending);
    next_cycle();
  endtask

  // kind 0 is iretd, 1 far return, 2 near return
  task automatic run_return(input int kind);
    logic [31:0] word;
    logic [15:0] cs_used;
    int          d;
    cs_register = $random(seed);
    cs_used = cs_register;
    iretd = (kind == 0);
    ret_far = (kind == 1);
    // a far return may see ret_near at the same time and must win
    ret_near = (kind == 2) || ((kind == 1) && $random(seed) % 2 != 0);
    next_cycle();
    iretd = 1'b0;
    ret_far = 1'b0;
    ret_near = 1'b0;
    for (int step = kind; step < 3; step++) begin
      d = {$random(seed)} % 4;
      repeat (d) begin
        iretd_pop_valid = 1'b0;
        iretd_pop_data = $random(seed);
        #1;
        compare("iretd_halt", iretd_halt, 1);
        compare("flush_fetch", flush_fetch, 1);
        compare("reg_load_eflags", reg_load_eflags, 0);
        compare("reg_load_cs", reg_load_cs, 0);
        compare("reg_load_eip", reg_load_eip, 0);
        next_cycle();
      end
      word = $random(seed);
      iretd_pop_valid = 1'b1;
      iretd_pop_data = word;
      #1;
      compare("iretd_halt", iretd_halt, 1);
      compare("flush_fetch", flush_fetch, 1);
      compare("reg_load_eflags", reg_load_eflags, step == 0);
      compare("reg_load_cs", reg_load_cs, step == 1);
      compare("reg_load_eip", reg_load_eip, step == 2);
      compare("fetch_load", fetch_load, step == 2);
      if (step == 0) begin
        compare("reg_eflags", reg_eflags, word);
      end else if (step == 1) begin
        compare("reg_cs", reg_cs, word[15:0]);
        cs_used = word[15:0];
      end else begin
        compare("reg_eip", reg_eip, word);
        compare("fetch_load_address", fetch_load_address, word + {16'h0, cs_used});
      end
      next_cycle();
    end
    iretd_pop_valid = 1'b0;
    #1;
    compare("iretd_halt", iretd_halt, 0);
    compare("flush_fetch", flush_fetch, 0);
    next_cycle();
  endtask

  //////////////////////////////
  // run

  initial begin
    seed = 32'h6f5f_96e9;
    errors = 0;
    checks = 0;
    tests_failed = 0;
    model_pending = 4'd0;
    arst_n = 1'b0;
    int_vec = 4'd0;
    cs_register = 16'd0;
    mem_ready = 1'b0;
    mem_dp_valid = 1'b0;
    mem_dp_read_data = 32'd0;
    decode_end_int = 1'b0;
    ret_near = 1'b0;
    ret_far = 1'b0;
    iretd = 1'b0;
    iretd_pop_valid = 1'b0;
    iretd_pop_data = 32'd0;
    hold_int = 1'b0;
    jump_load = 1'b0;
    jump_load_address = 32'd0;
    jump_load_cs = 1'b0;
    jump_cs = 16'd0;
    repeat (16) @(posedge clk);
    next_cycle();
    arst_n = 1'b1;
    #1;
    check_quiet();
    next_cycle();

    err0 = errors;
    repeat (N_JUMP) run_jump();
    end_test(1, "jump", err0);

    err0 = errors;
    repeat (N_ROUND) begin
      mask = $random(seed);
      if (mask == 4'd0) begin
        mask = 4'b1000;
      end
      int_vec = mask;
      model_pending = model_pending | mask;
      next_cycle();
      int_vec = 4'd0;
      while (model_pending != 4'd0) serve_one(4'd0);
    end
    end_test(2, "interrupt service", err0);

    err0 = errors;
    repeat (N_HOLD) begin
      hold_int = 1'b1;
      mask = $random(seed);
      if (mask == 4'd0) begin
        mask = 4'b0010;
      end
      int_vec = mask;
      model_pending = model_pending | mask;
      next_cycle();
      int_vec = 4'd0;
      repeat (6) begin
        #1;
        compare("pending_int", pending_int, 1);
        compare("mem_valid", mem_valid, 0);
        next_cycle();
      end
      hold_int = 1'b0;
      inject = $random(seed);
      inject[lowest_set(model_pending)] = 1'b0;
      serve_one(inject);
      while (model_pending != 4'd0) serve_one(4'd0);
    end
    end_test(3, "hold_int", err0);

    err0 = errors;
    repeat (N_RET) run_return(0);
    end_test(4, "iretd", err0);

    err0 = errors;
    repeat (N_RET) run_return(1 + {$random(seed)} % 2);
    // reset in the middle of a far return with an interrupt pending
    ret_far = 1'b1;
    int_vec = 4'b0100;
    next_cycle();
    ret_far = 1'b0;
    int_vec = 4'd0;
    iretd_pop_valid = 1'b1;
    iretd_pop_data = $random(seed);
    next_cycle();
    iretd_pop_valid = 1'b0;
    arst_n = 1'b0;
    model_pending = 4'd0;
    #1;
    check_quiet();
    repeat (2) next_cycle();
    arst_n = 1'b1;
    #1;
    check_quiet();
    next_cycle();
    end_test(5, "far and near returns", err0);

    $display("tests: 5 run, %0d failed; checks: %0d, errors: %0d", tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not end within %0d cycles", LIMIT);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
